/* Bender.yml */
package:
  name: div_accel

sources:
  - src/div_pkg.sv
  - src/clz.sv
  - src/div_quick_clz.sv
  - src/div_unit.sv
  - src/div_wb_regs.sv
  - src/div_top.sv
  - target: test
    files:
      - bench/div_tb.sv

/* bench/div_tb.sv */
//####################
// Division accelerator testbench
// Directed bus, divide, sign, zero divisor and back-pressure tests
//####################

`default_nettype none

module div_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH = 32;
    localparam int SEL_W = DATA_WIDTH / 8;
    // Divisions over the whole run, rounded up
    localparam int NUM_RUNS = 600;
    // Worst-case core latency plus register writes and status polls
    localparam int CYCLES_PER_RUN = 40 + 40;
    localparam int WATCHDOG_NS = NUM_RUNS * CYCLES_PER_RUN * 20 * 2;
    localparam int POLL_LIMIT = 100;
    localparam int ACK_LIMIT = 16;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [2:0]            wb_adr;
    logic [DATA_WIDTH-1:0] wb_dat_w;
    logic [SEL_W-1:0]      wb_sel;
    logic [DATA_WIDTH-1:0] wb_dat_r;
    logic                  wb_ack;

    int                    result_errs = 0;
    int                    status_errs = 0;
    int                    ack_errs = 0;
    int                    other_errs = 0;
    logic [31:0]           rng_state = 32'h2feb;

    div_top #(.DATA_WIDTH(DATA_WIDTH)) dut_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    // 50 MHz
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // RISC-V division rules
    function automatic logic [DATA_WIDTH-1:0] ref_div(input div_pkg::div_op_t op,
                                                     input logic [DATA_WIDTH-1:0] a,
                                                     input logic [DATA_WIDTH-1:0] b);
        logic signed [DATA_WIDTH-1:0] sa;
        logic signed [DATA_WIDTH-1:0] sb;
        logic                         is_rem;
        logic                         ovf;
        sa     = a;
        sb     = b;
        is_rem = (op == div_pkg::DIV_OP_REM) || (op == div_pkg::DIV_OP_REMU);
        // Most negative value over minus one
        ovf    = (a == {1'b1, {(DATA_WIDTH-1){1'b0}}}) && (b == '1);
        if (b == '0) begin
            return is_rem ? a : '1;
        end else if (op == div_pkg::DIV_OP_DIVU) begin
            return a / b;
        end else if (op == div_pkg::DIV_OP_REMU) begin
            return a % b;
        end else if (ovf) begin
            return is_rem ? '0 : a;
        end else if (op == div_pkg::DIV_OP_DIV) begin
            return sa / sb;
        end
        return sa % sb;
    endfunction

    task automatic check_result(input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            result_errs++;
        end
    endtask

    task automatic check_status(input logic [2:0] got, input logic [2:0] exp,
                                input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s status %b expected %b", $time, msg, got, exp);
            status_errs++;
        end
    endtask

    // Ack exactly one cycle after strobe, low again the cycle after
    task automatic check_ack(input int latency, input logic ack_next, input string msg);
        if (latency != 1 || ack_next !== 1'b0) begin
            $display("CHECK FAILED at %0t: %s ack latency %0d, ack held %b",
                     $time, msg, latency, ack_next);
            ack_errs++;
        end
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic bus_cycle(input logic we, input logic [2:0] adr,
                             input logic [DATA_WIDTH-1:0] data, input logic [SEL_W-1:0] sel,
                             output logic [DATA_WIDTH-1:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = sel;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (wb_ack !== 1'b1 && waited < ACK_LIMIT);
        rdata = wb_dat_r;
        if (wb_ack !== 1'b1) begin
            $display("Bus error at %0t: no acknowledge for address %0d", $time, adr);
            other_errs++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #2;
        check_ack(waited, wb_ack, $sformatf("%s address %0d", we ? "write" : "read", adr));
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [DATA_WIDTH-1:0] data,
                            input logic [SEL_W-1:0] sel);
        logic [DATA_WIDTH-1:0] unused;
        bus_cycle(1'b1, adr, data, sel, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [DATA_WIDTH-1:0] data);
        bus_cycle(1'b0, adr, '0, '0, data);
    endtask

    // Poll STATUS until the done bit shows
    task automatic wait_done(output logic [2:0] status);
        logic [DATA_WIDTH-1:0] rd;
        int                    polls;
        polls = 0;
        rd    = '0;
        while (rd[div_pkg::STATUS_DONE] !== 1'b1 && polls < POLL_LIMIT) begin
            wb_read(div_pkg::REG_STATUS, rd);
            polls++;
        end
        if (rd[div_pkg::STATUS_DONE] !== 1'b1) begin
            $display("Error at %0t: division never completed", $time);
            other_errs++;
        end
        status = rd[2:0];
    endtask

    task automatic run_div(input div_pkg::div_op_t op, input logic [DATA_WIDTH-1:0] a,
                           input logic [DATA_WIDTH-1:0] b, output logic [DATA_WIDTH-1:0] res,
                           output logic [2:0] status);
        wb_write(div_pkg::REG_DIVIDEND, a, '1);
        wb_write(div_pkg::REG_DIVISOR, b, '1);
        wb_write(div_pkg::REG_CONTROL, DATA_WIDTH'(op), '1);
        wait_done(status);
        wb_read(div_pkg::REG_RESULT, res);
    endtask

    // One division checked against the model, status included
    task automatic check_div(input div_pkg::div_op_t op, input logic [DATA_WIDTH-1:0] a,
                             input logic [DATA_WIDTH-1:0] b,
                             output logic [DATA_WIDTH-1:0] res);
        logic [2:0] st;
        logic [2:0] exp_st;
        string      msg;
        exp_st                       = '0;
        exp_st[div_pkg::STATUS_DONE] = 1'b1;
        exp_st[div_pkg::STATUS_DBZ]  = (b == '0);
        msg = $sformatf("op %0d %h / %h", op, a, b);
        run_div(op, a, b, res, st);
        check_result(res, ref_div(op, a, b), msg);
        check_status(st, exp_st, msg);
    endtask

    task automatic unsigned_pair(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [DATA_WIDTH-1:0] q;
        logic [DATA_WIDTH-1:0] r;
        check_div(div_pkg::DIV_OP_DIVU, a, b, q);
        check_div(div_pkg::DIV_OP_REMU, a, b, r);
        // q * b + r rebuilds the dividend
        check_result(q * b + r, a, $sformatf("identity %h / %h", a, b));
    endtask

    task automatic signed_pair(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [DATA_WIDTH-1:0] res;
        check_div(div_pkg::DIV_OP_DIV, a, b, res);
        check_div(div_pkg::DIV_OP_REM, a, b, res);
    endtask

    task automatic test_register_access();
        logic [DATA_WIDTH-1:0] rd;
        wb_write(div_pkg::REG_DIVIDEND, 32'hdead_beef, 4'hf);
        wb_read(div_pkg::REG_DIVIDEND, rd);
        check_result(rd, 32'hdead_beef, "dividend readback");
        wb_write(div_pkg::REG_DIVISOR, 32'h1234_5678, 4'hf);
        wb_read(div_pkg::REG_DIVISOR, rd);
        check_result(rd, 32'h1234_5678, "divisor readback");
        // Bytes 2 and 0 only
        wb_write(div_pkg::REG_DIVIDEND, 32'haabb_ccdd, 4'b0101);
        wb_read(div_pkg::REG_DIVIDEND, rd);
        check_result(rd, 32'hdebb_bedd, "dividend partial write");
        // Bytes 3 and 1 only
        wb_write(div_pkg::REG_DIVISOR, 32'haabb_ccdd, 4'b1010);
        wb_read(div_pkg::REG_DIVISOR, rd);
        check_result(rd, 32'haa34_cc78, "divisor partial write");
    endtask

    task automatic test_unsigned();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [31:0]           sh;
        unsigned_pair(32'd1, 32'd1);
        unsigned_pair('1, 32'd1);
        unsigned_pair('1, '1);
        unsigned_pair('1, 32'd2);
        unsigned_pair('1, 32'h8000_0000);
        unsigned_pair(32'h8000_0000, 32'h10);
        unsigned_pair(32'h0001_0000, 32'h100);
        unsigned_pair(32'd5, 32'd9);
        unsigned_pair(32'd0, 32'd3);
        unsigned_pair(32'd1000, 32'd1);
        unsigned_pair(32'd12345678, 32'd3);
        for (int i = 0; i < 200; i++) begin
            a  = next_rand();
            sh = next_rand();
            // Spread divisor sizes to vary the latency
            b  = next_rand() >> sh[4:0];
            if (b == '0) begin
                b = 32'd1;
            end
            unsigned_pair(a, b);
        end
    endtask

    task automatic test_signed();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [31:0]           sh;
        signed_pair(32'd100, 32'd7);
        signed_pair(-32'sd100, 32'd7);
        signed_pair(32'd100, -32'sd7);
        signed_pair(-32'sd100, -32'sd7);
        signed_pair(32'd7, -32'sd100);
        signed_pair(32'h8000_0000, '1);
        signed_pair(32'h8000_0000, 32'd1);
        signed_pair('1, 32'h8000_0000);
        for (int i = 0; i < 60; i++) begin
            a  = next_rand();
            sh = next_rand();
            b  = next_rand() >> sh[4:0];
            if (b == '0) begin
                b = 32'd1;
            end
            // Random sign on the divisor
            if (sh[8]) begin
                b = -b;
            end
            signed_pair(a, b);
        end
    endtask

    task automatic test_back_pressure();
        logic [DATA_WIDTH-1:0] rd;
        logic [2:0]            st;
        // Slow case, two quotient bits per cycle over the full width
        wb_write(div_pkg::REG_DIVIDEND, '1, '1);
        wb_write(div_pkg::REG_DIVISOR, 32'd1, '1);
        wb_write(div_pkg::REG_CONTROL, DATA_WIDTH'(div_pkg::DIV_OP_DIVU), '1);
        wb_read(div_pkg::REG_STATUS, rd);
        check_status(rd[2:0], 3'b001, "busy before done");
        // New operand and op while running
        wb_write(div_pkg::REG_DIVIDEND, 32'h0001_2345, '1);
        wb_write(div_pkg::REG_CONTROL, DATA_WIDTH'(div_pkg::DIV_OP_REMU), '1);
        wait_done(st);
        check_status(st, 3'b010, "back-pressure completion");
        wb_read(div_pkg::REG_RESULT, rd);
        check_result(rd, ref_div(div_pkg::DIV_OP_DIVU, '1, 32'd1), "first result kept");
        wb_read(div_pkg::REG_DIVIDEND, rd);
        check_result(rd, 32'h0001_2345, "dividend copy written while busy");
    endtask

    task automatic test_div_by_zero();
        logic [DATA_WIDTH-1:0] res;
        check_div(div_pkg::DIV_OP_DIV, 32'h8765_4321, '0, res);
        check_div(div_pkg::DIV_OP_DIVU, 32'h8765_4321, '0, res);
        check_div(div_pkg::DIV_OP_REM, 32'h8765_4321, '0, res);
        check_div(div_pkg::DIV_OP_REMU, 32'h8765_4321, '0, res);
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        rst      = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        test_register_access();
        test_unsigned();
        test_signed();
        // Stale zero divisor flag would show in the busy status
        test_back_pressure();
        test_div_by_zero();
        $display("Errors: result %0d, status %0d, handshake %0d, other %0d",
                 result_errs, status_errs, ack_errs, other_errs);
        if (result_errs + status_errs + ack_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/div_pkg.sv
src/clz.sv
src/div_quick_clz.sv
src/div_unit.sv
src/div_wb_regs.sv
src/div_top.sv
bench/div_tb.sv

/* src/clz.sv */
//####################
// Count leading zeros
// Tree of two-input priority encoders returning all ones on zero input
//####################

`default_nettype none

module clz #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0]         clz_input,
    output logic [$clog2(DATA_WIDTH)-1:0] clz
);

    localparam int CLZ_W = $clog2(DATA_WIDTH);

    // Node counts per level padded to full width
    logic [CLZ_W-1:0] cnt [CLZ_W][DATA_WIDTH/2];
    // Node covers only zero bits
    logic             zero_flag [CLZ_W][DATA_WIDTH/2];

    genvar lvl;
    genvar node;

    // Leaves look at bit pairs
    for (node = 0; node < DATA_WIDTH / 2; node++) begin : g_leaf
        assign zero_flag[0][node] = ~|clz_input[2*node +: 2];
        assign cnt[0][node]       = {{(CLZ_W-1){1'b0}}, ~clz_input[2*node+1]};
    end

    // Each level merges an upper and a lower child
    for (lvl = 1; lvl < CLZ_W; lvl++) begin : g_level
        for (node = 0; node < (DATA_WIDTH >> (lvl + 1)); node++) begin : g_node
            assign zero_flag[lvl][node] = zero_flag[lvl-1][2*node+1]
                                        & zero_flag[lvl-1][2*node];
            // Empty upper child adds its whole span to the lower count
            assign cnt[lvl][node] = zero_flag[lvl-1][2*node+1]
                                  ? ((CLZ_W'(1) << lvl) | cnt[lvl-1][2*node])
                                  : cnt[lvl-1][2*node+1];
        end
    end

    // Root of the tree
    assign clz = cnt[CLZ_W-1][0];

endmodule

`default_nettype wire

/* src/div_pkg.sv */
//####################
// Division accelerator shared definitions
// Operation codes, register word map and status bits
//####################

`default_nettype none

package div_pkg;

    // Operation select, written to bits 1:0 of the control register
    typedef enum logic [1:0] {
        // Signed quotient
        DIV_OP_DIV  = 2'd0,
        // Unsigned quotient
        DIV_OP_DIVU = 2'd1,
        // Signed remainder
        DIV_OP_REM  = 2'd2,
        // Unsigned remainder
        DIV_OP_REMU = 2'd3
    } div_op_t;

    // Register word indices on the slave bus
    localparam logic [2:0] REG_DIVIDEND = 3'd0;
    localparam logic [2:0] REG_DIVISOR  = 3'd1;
    // Write launches a division
    localparam logic [2:0] REG_CONTROL  = 3'd2;
    // Read only
    localparam logic [2:0] REG_STATUS   = 3'd3;
    localparam logic [2:0] REG_RESULT   = 3'd4;

    // Bit positions inside the status word
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_DONE = 1;
    localparam int STATUS_DBZ  = 2;

endpackage

`default_nettype wire

/* src/div_quick_clz.sv */
//####################
// Quick unsigned divider core
// CLZ-aligned subtraction, one or two quotient bits per cycle
//####################

`default_nettype none

module div_quick_clz #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    output logic [DATA_WIDTH-1:0] quotient,
    output logic [DATA_WIDTH-1:0] remainder,
    output logic                  done,
    output logic                  divisor_is_zero
);

    localparam int CLZ_W = $clog2(DATA_WIDTH);

    logic                  running;
    logic                  terminate;
    logic                  iterate;

    logic [CLZ_W-1:0]      r_clz;
    logic [CLZ_W-1:0]      b_clz;
    logic [CLZ_W-1:0]      b_clz_r;
    logic [CLZ_W-1:0]      clz_delta;

    // Divisor shifted up to the top bit
    logic [DATA_WIDTH-1:0] b_norm;
    logic [DATA_WIDTH-1:0] b1;
    logic [DATA_WIDTH-1:0] b2;

    // Trial differences, extra top bits act as borrow
    logic [DATA_WIDTH+1:0] a0;
    logic [DATA_WIDTH:0]   a1;
    logic [DATA_WIDTH-1:0] a2;

    logic [DATA_WIDTH-1:0] q_bit1;
    logic [DATA_WIDTH-1:0] q_bit2;
    logic [DATA_WIDTH-1:0] new_q_bits;
    logic [DATA_WIDTH-1:0] new_r;

    clz #(.DATA_WIDTH(DATA_WIDTH)) clz_r_i (.clz_input(remainder), .clz(r_clz));
    clz #(.DATA_WIDTH(DATA_WIDTH)) clz_b_i (.clz_input(divisor), .clz(b_clz));

    // Divisor stays stable while running, so normalize once
    always_ff @(posedge clk) begin
        if (start) begin
            b_clz_r <= b_clz;
            b_norm  <= divisor << b_clz;
        end
    end

    // Quotient bit weight for the aligned divisor
    assign clz_delta = b_clz_r - r_clz;

    always_comb begin
        q_bit1            = '0;
        q_bit1[clz_delta] = 1'b1;
    end
    assign q_bit2 = q_bit1 >> 1;

    // Divisor aligned under the remainder's leading one, and its half
    assign b1 = b_norm >> r_clz;
    assign b2 = b1 >> 1;

    // Try 1x, 1.5x and 0.5x of the aligned divisor
    assign a1 = {1'b0, remainder} - {1'b0, b1};
    assign a0 = {2'b00, remainder} - ({2'b00, b1} + {2'b00, b2});
    assign a2 = remainder - b2;

    // Largest multiple that keeps the remainder non-negative
    always_comb begin
        if (a1[DATA_WIDTH]) begin
            new_q_bits = q_bit2;
            new_r      = a2;
        end else if (a0[DATA_WIDTH+1] || clz_delta == '0) begin
            new_q_bits = q_bit1;
            new_r      = a1[DATA_WIDTH-1:0];
        end else begin
            new_q_bits = q_bit1 | q_bit2;
            new_r      = a0[DATA_WIDTH-1:0];
        end
    end

    // Zero divisor gives all ones from the encoder with bit 0 clear
    assign divisor_is_zero = (b_clz == '1) && !divisor[0];

    assign terminate = remainder < divisor;
    assign iterate   = running & ~terminate;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (start && !divisor_is_zero) begin
                running <= 1'b1;
            end else if (terminate) begin
                running <= 1'b0;
            end
            // Zero divisor finishes right after start
            done <= (running & terminate) | (start & divisor_is_zero);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quotient  <= '0;
            remainder <= dividend;
        end else if (iterate) begin
            quotient  <= quotient | new_q_bits;
            remainder <= new_r;
        end
    end

endmodule

`default_nettype wire

/* src/div_top.sv */
//####################
// Division accelerator top
// Wishbone slave registers around the division unit
//####################

`default_nettype none

module div_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [2:0]              wb_adr,
    input  logic [DATA_WIDTH-1:0]   wb_dat_w,
    input  logic [DATA_WIDTH/8-1:0] wb_sel,
    output logic [DATA_WIDTH-1:0]   wb_dat_r,
    output logic                    wb_ack
);

    // Request path
    logic                  start;
    div_pkg::div_op_t      op;
    logic [DATA_WIDTH-1:0] dividend;
    logic [DATA_WIDTH-1:0] divisor;

    // Completion path
    logic                  busy;
    logic                  done;
    logic [DATA_WIDTH-1:0] result;
    logic                  div_by_zero;

    div_wb_regs #(.DATA_WIDTH(DATA_WIDTH)) regs_i (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .busy(busy), .done(done), .result(result), .div_by_zero(div_by_zero),
        .start(start), .op(op), .dividend(dividend), .divisor(divisor)
    );

    div_unit #(.DATA_WIDTH(DATA_WIDTH)) unit_i (
        .clk(clk), .rst(rst),
        .start(start), .op(op), .dividend(dividend), .divisor(divisor),
        .busy(busy), .done(done), .result(result), .div_by_zero(div_by_zero)
    );

endmodule

`default_nettype wire

/* src/div_unit.sv */
//####################
// Division unit
// Signed and unsigned div/rem with RISC-V result rules
//####################

`default_nettype none

module div_unit #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  div_pkg::div_op_t      op,
    input  logic [DATA_WIDTH-1:0] dividend,
    input  logic [DATA_WIDTH-1:0] divisor,
    output logic                  busy,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  div_by_zero
);

    logic                  accept;
    logic                  is_signed;
    logic                  neg_dividend;
    logic                  neg_divisor;

    // Latched request
    div_pkg::div_op_t      op_r;
    logic                  q_neg;
    logic                  r_neg;
    logic [DATA_WIDTH-1:0] dividend_r;

    logic                  core_start;
    logic [DATA_WIDTH-1:0] core_dividend;
    logic [DATA_WIDTH-1:0] core_divisor;
    logic [DATA_WIDTH-1:0] core_quotient;
    logic [DATA_WIDTH-1:0] core_remainder;
    logic                  core_done;
    logic                  core_dbz;

    logic [DATA_WIDTH-1:0] final_q;
    logic [DATA_WIDTH-1:0] final_r;
    logic                  is_rem;

    // Requests while busy are dropped
    assign accept = start & ~busy;

    assign is_signed    = (op == div_pkg::DIV_OP_DIV) || (op == div_pkg::DIV_OP_REM);
    assign neg_dividend = is_signed & dividend[DATA_WIDTH-1];
    assign neg_divisor  = is_signed & divisor[DATA_WIDTH-1];

    // Magnitudes and result signs, most negative value maps to itself
    always_ff @(posedge clk) begin
        if (accept) begin
            op_r          <= op;
            q_neg         <= neg_dividend ^ neg_divisor;
            r_neg         <= neg_dividend;
            dividend_r    <= dividend;
            core_dividend <= neg_dividend ? -dividend : dividend;
            core_divisor  <= neg_divisor ? -divisor : divisor;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            core_start <= 1'b0;
        end else begin
            // Core starts once magnitudes are registered
            core_start <= accept;
            done       <= core_done;
            if (accept) begin
                busy <= 1'b1;
            end else if (core_done) begin
                busy <= 1'b0;
            end
        end
    end

    div_quick_clz #(.DATA_WIDTH(DATA_WIDTH)) core_i (
        .clk            (clk),
        .rst            (rst),
        .start          (core_start),
        .dividend       (core_dividend),
        .divisor        (core_divisor),
        .quotient       (core_quotient),
        .remainder      (core_remainder),
        .done           (core_done),
        .divisor_is_zero(core_dbz)
    );

    // Sign correction, zero divisor overrides
    assign final_q = core_dbz ? '1 : (q_neg ? -core_quotient : core_quotient);
    assign final_r = core_dbz ? dividend_r : (r_neg ? -core_remainder : core_remainder);
    assign is_rem  = (op_r == div_pkg::DIV_OP_REM) || (op_r == div_pkg::DIV_OP_REMU);

    always_ff @(posedge clk) begin
        if (core_done) begin
            result      <= is_rem ? final_r : final_q;
            div_by_zero <= core_dbz;
        end
    end

endmodule

`default_nettype wire

/* src/div_wb_regs.sv */
//####################
// Wishbone classic register file
// Operands, control, status and result of the divider
//####################

`default_nettype none

module div_wb_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [2:0]              wb_adr,
    input  logic [DATA_WIDTH-1:0]   wb_dat_w,
    input  logic [DATA_WIDTH/8-1:0] wb_sel,
    output logic [DATA_WIDTH-1:0]   wb_dat_r,
    output logic                    wb_ack,
    input  logic                    busy,
    input  logic                    done,
    input  logic [DATA_WIDTH-1:0]   result,
    input  logic                    div_by_zero,
    output logic                    start,
    output div_pkg::div_op_t        op,
    output logic [DATA_WIDTH-1:0]   dividend,
    output logic [DATA_WIDTH-1:0]   divisor
);

    localparam int SEL_W = DATA_WIDTH / 8;

    logic                  access;
    logic                  wr_access;
    logic                  launch;
    logic                  done_flag;
    logic [DATA_WIDTH-1:0] result_r;
    logic                  dbz_r;
    logic [DATA_WIDTH-1:0] rd_data;

    // New request seen while no ack is out
    assign access    = wb_cyc & wb_stb & ~wb_ack;
    assign wr_access = access & wb_we;
    // Control write only launches when idle
    assign launch    = wr_access && (wb_adr == div_pkg::REG_CONTROL) && !busy;

    // Single-cycle ack, one clock after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
            start  <= 1'b0;
        end else begin
            wb_ack <= access;
            start  <= launch;
        end
    end

    // Operand registers with byte enables
    always_ff @(posedge clk) begin
        if (wr_access) begin
            for (int b = 0; b < SEL_W; b++) begin
                if (wb_sel[b]) begin
                    if (wb_adr == div_pkg::REG_DIVIDEND) begin
                        dividend[8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                    if (wb_adr == div_pkg::REG_DIVISOR) begin
                        divisor[8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end
        end
        if (launch) begin
            op <= div_pkg::div_op_t'(wb_dat_w[1:0]);
        end
    end

    // Sticky done, cleared by the next launch
    always_ff @(posedge clk) begin
        if (rst) begin
            done_flag <= 1'b0;
        end else if (done) begin
            done_flag <= 1'b1;
        end else if (launch) begin
            done_flag <= 1'b0;
        end
    end

    // Hold result steady for software reads
    always_ff @(posedge clk) begin
        if (done) begin
            result_r <= result;
            dbz_r    <= div_by_zero;
        end
    end

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            div_pkg::REG_DIVIDEND: rd_data = dividend;
            div_pkg::REG_DIVISOR:  rd_data = divisor;
            div_pkg::REG_CONTROL:  rd_data[1:0] = op;
            div_pkg::REG_STATUS: begin
                rd_data[div_pkg::STATUS_BUSY] = busy;
                rd_data[div_pkg::STATUS_DONE] = done_flag;
                rd_data[div_pkg::STATUS_DBZ]  = dbz_r;
            end
            div_pkg::REG_RESULT:   rd_data = result_r;
            default:               rd_data = '0;
        endcase
    end

    // Read data valid alongside ack
    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire
